// File: Makefile
TOP := mbox_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "simulator exited with an error" >> $(LOG)
	cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "NO ERRORS" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
hw/mbox_pkg.sv
hw/smart_fifo.sv
hw/mbox_regs.sv
hw/mbox_top.sv
tests/mbox_sva.sv
tests/mbox_tb.sv

// File: hw/mbox_pkg.sv
package mbox_pkg;

    // Payload and tag widths
    localparam int DATA_W = 32;
    localparam int TAG_W  = 4;

    // FIFO geometry, both FIFOs share one depth
    localparam int FIFO_AW = 3;
    localparam int CNT_W   = FIFO_AW + 1;
    localparam logic [CNT_W-1:0] FIFO_DEPTH = CNT_W'(1 << FIFO_AW);

    // almost_full at depth minus AF_THRESH and above
    localparam int AF_THRESH = 2;
    // almost_empty at AE_THRESH and below, while not empty
    localparam int AE_THRESH = 2;

    // Error counter per FIFO
    localparam int ERR_W = 16;

    // AXI4-Lite
    localparam int AXI_AW = 8;
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Register map, byte offsets
    localparam logic [AXI_AW-1:0] REG_TX_DATA   = 8'h00;
    localparam logic [AXI_AW-1:0] REG_RX_DATA   = 8'h04;
    localparam logic [AXI_AW-1:0] REG_RX_TAG    = 8'h08;
    localparam logic [AXI_AW-1:0] REG_STATUS    = 8'h0C;
    localparam logic [AXI_AW-1:0] REG_ERR_COUNT = 8'h10;
    localparam logic [AXI_AW-1:0] REG_CTRL      = 8'h14;

    // CTRL bit that clears the sticky error flags
    localparam int CTRL_CLEAR_BIT = 0;

    // Receive FIFO entry, tag in the upper bits
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } rx_entry_t;

endpackage

// File: hw/mbox_regs.sv
`timescale 1ns/1ps

module mbox_regs
    import mbox_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // AXI4-Lite write address and data
    input  logic [AXI_AW-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [DATA_W-1:0] wdata,
    input  logic              wvalid,
    output logic              wready,

    // AXI4-Lite write response
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,

    // AXI4-Lite read
    input  logic [AXI_AW-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [DATA_W-1:0] rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready,

    // Transmit FIFO
    output logic              tx_push,
    output logic [DATA_W-1:0] tx_data,
    input  logic [CNT_W-1:0]  tx_count,
    input  logic              tx_full,
    input  logic              tx_almost_full,
    input  logic              tx_err,
    input  logic [ERR_W-1:0]  tx_err_count,

    // Receive FIFO
    output logic              rx_pop,
    input  rx_entry_t         rx_head,
    input  logic [CNT_W-1:0]  rx_count,
    input  logic              rx_empty,
    input  logic              rx_almost_empty,
    input  logic              rx_err,
    input  logic [ERR_W-1:0]  rx_err_count,

    output logic              clear_errors
);

    logic              wr_accept;
    logic              rd_accept;
    logic [DATA_W-1:0] status_word;
    logic [DATA_W-1:0] rd_mux;

    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;

    // Address and data taken in one beat, held off while a response is pending
    assign wr_accept = awvalid && wvalid && !bvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;

    // Write side effects fire in the accept cycle
    assign tx_push      = wr_accept && (awaddr == REG_TX_DATA);
    assign tx_data      = wdata;
    assign clear_errors = wr_accept && (awaddr == REG_CTRL) && wdata[CTRL_CLEAR_BIT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bvalid <= 1'b0;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // One read in flight at a time
    assign rd_accept = arvalid && !rvalid;
    assign arready   = rd_accept;
    assign rx_pop    = rd_accept && (araddr == REG_RX_DATA);

    always_comb begin
        status_word        = '0;
        status_word[3:0]   = tx_count;
        status_word[4]     = tx_full;
        status_word[5]     = tx_almost_full;
        status_word[6]     = tx_err;
        status_word[11:8]  = rx_count;
        status_word[12]    = rx_empty;
        status_word[13]    = rx_almost_empty;
        status_word[14]    = rx_err;
    end

    always_comb begin
        case (araddr)
            REG_RX_DATA:   rd_mux = rx_head.data;
            REG_RX_TAG:    rd_mux = {{(DATA_W-TAG_W){1'b0}}, rx_head.tag};
            REG_STATUS:    rd_mux = status_word;
            REG_ERR_COUNT: rd_mux = {rx_err_count, tx_err_count};
            default:       rd_mux = '0;
        endcase
    end

    // Head is sampled before the pop lands
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_mux;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

endmodule

// File: hw/mbox_top.sv
`timescale 1ns/1ps

module mbox_top
    import mbox_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,

    // AXI4-Lite slave
    input  logic [AXI_AW-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [DATA_W-1:0] wdata,
    input  logic              wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [AXI_AW-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [DATA_W-1:0] rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready,

    // Device drains tx
    input  logic              dev_tx_pop,
    output logic [DATA_W-1:0] dev_tx_data,
    output logic              dev_tx_valid,

    // Device fills rx
    input  logic              dev_rx_push,
    input  logic [DATA_W-1:0] dev_rx_data,
    input  logic [TAG_W-1:0]  dev_rx_tag,
    output logic              dev_rx_ready
);

    logic              tx_push;
    logic [DATA_W-1:0] tx_data;
    logic [CNT_W-1:0]  tx_count;
    logic              tx_full;
    logic              tx_almost_full;
    logic              tx_err;
    logic [ERR_W-1:0]  tx_err_count;

    logic              rx_pop;
    rx_entry_t         rx_head;
    rx_entry_t         rx_wr_entry;
    logic [CNT_W-1:0]  rx_count;
    logic              rx_empty;
    logic              rx_almost_empty;
    logic              rx_err;
    logic [ERR_W-1:0]  rx_err_count;

    logic              clear_errors;

    assign rx_wr_entry.tag  = dev_rx_tag;
    assign rx_wr_entry.data = dev_rx_data;

    mbox_regs u_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .awaddr          (awaddr),
        .awvalid         (awvalid),
        .awready         (awready),
        .wdata           (wdata),
        .wvalid          (wvalid),
        .wready          (wready),
        .bresp           (bresp),
        .bvalid          (bvalid),
        .bready          (bready),
        .araddr          (araddr),
        .arvalid         (arvalid),
        .arready         (arready),
        .rdata           (rdata),
        .rresp           (rresp),
        .rvalid          (rvalid),
        .rready          (rready),
        .tx_push         (tx_push),
        .tx_data         (tx_data),
        .tx_count        (tx_count),
        .tx_full         (tx_full),
        .tx_almost_full  (tx_almost_full),
        .tx_err          (tx_err),
        .tx_err_count    (tx_err_count),
        .rx_pop          (rx_pop),
        .rx_head         (rx_head),
        .rx_count        (rx_count),
        .rx_empty        (rx_empty),
        .rx_almost_empty (rx_almost_empty),
        .rx_err          (rx_err),
        .rx_err_count    (rx_err_count),
        .clear_errors    (clear_errors)
    );

    // Host writes, device reads
    smart_fifo #(
        .payload_t (logic [DATA_W-1:0])
    ) u_tx_fifo (
        .clk                (clk),
        .rst_n              (rst_n),
        .wr_en              (tx_push),
        .wr_data            (tx_data),
        .wr_ready           (),
        .overflow_detected  (),
        .rd_en              (dev_tx_pop),
        .rd_data            (dev_tx_data),
        .rd_valid           (dev_tx_valid),
        .underflow_detected (),
        .full               (tx_full),
        .almost_full        (tx_almost_full),
        .empty              (),
        .almost_empty       (),
        .data_count         (tx_count),
        .clear_errors       (clear_errors),
        .error_detected     (tx_err),
        .error_count        (tx_err_count)
    );

    // Device writes tagged words, host reads
    smart_fifo #(
        .payload_t (rx_entry_t)
    ) u_rx_fifo (
        .clk                (clk),
        .rst_n              (rst_n),
        .wr_en              (dev_rx_push),
        .wr_data            (rx_wr_entry),
        .wr_ready           (dev_rx_ready),
        .overflow_detected  (),
        .rd_en              (rx_pop),
        .rd_data            (rx_head),
        .rd_valid           (),
        .underflow_detected (),
        .full               (),
        .almost_full        (),
        .empty              (rx_empty),
        .almost_empty       (rx_almost_empty),
        .data_count         (rx_count),
        .clear_errors       (clear_errors),
        .error_detected     (rx_err),
        .error_count        (rx_err_count)
    );

endmodule

// File: hw/smart_fifo.sv
`timescale 1ns/1ps

module smart_fifo
    import mbox_pkg::*;
#(
    parameter type payload_t = logic [DATA_W-1:0]
) (
    input  logic             clk,
    input  logic             rst_n,

    // Write side
    input  logic             wr_en,
    input  payload_t         wr_data,
    output logic             wr_ready,
    output logic             overflow_detected,

    // Read side
    input  logic             rd_en,
    output payload_t         rd_data,
    output logic             rd_valid,
    output logic             underflow_detected,

    // Fill level
    output logic             full,
    output logic             almost_full,
    output logic             empty,
    output logic             almost_empty,
    output logic [CNT_W-1:0] data_count,

    // Error tracking
    input  logic             clear_errors,
    output logic             error_detected,
    output logic [ERR_W-1:0] error_count
);

    payload_t         mem [0:(1 << FIFO_AW)-1];
    logic [CNT_W-1:0] wr_ptr;
    logic [CNT_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_count;
    payload_t         last_popped;
    logic             do_write;
    logic             do_read;
    logic [1:0]       err_incr;

    // Extra pointer bit tells full from empty
    assign fifo_count = wr_ptr - rd_ptr;
    assign data_count = fifo_count;

    assign full         = (fifo_count == FIFO_DEPTH);
    assign empty        = (fifo_count == '0);
    assign almost_full  = (fifo_count >= FIFO_DEPTH - CNT_W'(AF_THRESH));
    assign almost_empty = (fifo_count <= CNT_W'(AE_THRESH)) && !empty;

    // Pushes into a full FIFO are dropped, so ready just mirrors full
    assign wr_ready          = !full;
    assign overflow_detected = wr_en && full;
    assign do_write          = wr_en && !full;

    assign rd_valid           = !empty;
    assign underflow_detected = rd_en && empty;
    assign do_read            = rd_en && !empty;

    // On empty, repeat whatever was popped last
    assign rd_data = empty ? last_popped : mem[rd_ptr[FIFO_AW-1:0]];

    // Both error sources can hit in the same cycle
    assign err_incr = {1'b0, overflow_detected} + {1'b0, underflow_detected};

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[FIFO_AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Zero until the first real pop
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_popped <= '0;
        end else if (do_read) begin
            last_popped <= mem[rd_ptr[FIFO_AW-1:0]];
        end
    end

    // Sticky flag, a new error wins over a clear in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            error_detected <= 1'b0;
        end else if (overflow_detected || underflow_detected) begin
            error_detected <= 1'b1;
        end else if (clear_errors) begin
            error_detected <= 1'b0;
        end
    end

    // Counter survives clear_errors
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            error_count <= '0;
        end else if (err_incr != 2'd0) begin
            error_count <= error_count + ERR_W'(err_incr);
        end
    end

endmodule

// File: tests/mbox_sva.sv
`timescale 1ns/1ps

module mbox_sva (
    input logic clk,
    input logic rst_n,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic tx_push,
    input logic rx_pop
);

    // Responses stay up until taken
    bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // Strobes are single cycle
    tx_push_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        tx_push |=> !tx_push)
        else $error("tx_push wider than one cycle");

    rx_pop_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_pop |=> !rx_pop)
        else $error("rx_pop wider than one cycle");

endmodule

bind mbox_regs mbox_sva u_sva (
    .clk     (clk),
    .rst_n   (rst_n),
    .bvalid  (bvalid),
    .bready  (bready),
    .rvalid  (rvalid),
    .rready  (rready),
    .tx_push (tx_push),
    .rx_pop  (rx_pop)
);

// File: tests/mbox_tb.sv
`timescale 1ns/1ps

module mbox_tb
    import mbox_pkg::*;
;

    logic              clk;
    logic              rst_n;
    logic [AXI_AW-1:0] awaddr;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic              wvalid;
    logic              wready;
    logic [1:0]        bresp;
    logic              bvalid;
    logic              bready;
    logic [AXI_AW-1:0] araddr;
    logic              arvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;
    logic [1:0]        rresp;
    logic              rvalid;
    logic              rready;
    logic              dev_tx_pop;
    logic [DATA_W-1:0] dev_tx_data;
    logic              dev_tx_valid;
    logic              dev_rx_push;
    logic [DATA_W-1:0] dev_rx_data;
    logic [TAG_W-1:0]  dev_rx_tag;
    logic              dev_rx_ready;

    // Trace contents, one entry per operation
    logic [31:0] op_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] data_q[$];
    int          test_q[$];

    int cycles = 0;
    int limit = 0;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int test_checks = 0;
    int test_errors = 0;
    int cur_test = 0;

    // Entries the rx FIFO should hold right now
    int rx_level = 0;

    mbox_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Run limit follows the trace length once it is loaded
    initial begin
        while (limit == 0 || cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a handshake never completed", cycles);
        $display("ERRORS FOUND");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        test_checks++;
        assert (got === exp) else begin
            $display("mismatch %s expected 0x%h got 0x%h in test %0d", name, exp, got, cur_test);
            errors++;
            test_errors++;
        end
    endtask

    task automatic report_test();
        tests++;
        $display("test %0d %s, %0d checks, %0d errors", cur_test,
                 (test_errors == 0) ? "ok" : "failed", test_checks, test_errors);
    endtask

    // All drivers start and end 1 ns after a rising edge
    task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [DATA_W-1:0] data);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        // Every response is OKAY
        check_value("bresp", 32'h0, {30'b0, bresp});
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_AW-1:0] addr, output logic [DATA_W-1:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        check_value("rresp", 32'h0, {30'b0, rresp});
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    // Ready drops only once the rx FIFO holds a full depth
    task automatic device_push(input logic [TAG_W-1:0] tag, input logic [DATA_W-1:0] data);
        check_value("dev_rx_ready", (rx_level < (1 << FIFO_AW)) ? 32'h1 : 32'h0,
                    {31'b0, dev_rx_ready});
        if (rx_level < (1 << FIFO_AW)) begin
            rx_level++;
        end
        dev_rx_push = 1'b1;
        dev_rx_tag  = tag;
        dev_rx_data = data;
        @(posedge clk);
        #1;
        dev_rx_push = 1'b0;
    endtask

    // Head is checked first, the pop only goes out when data is expected
    task automatic device_pop(input logic exp_valid, input logic [DATA_W-1:0] exp_data);
        check_value("dev_tx_valid", {31'b0, exp_valid}, {31'b0, dev_tx_valid});
        check_value("dev_tx_data", exp_data, dev_tx_data);
        dev_tx_pop = exp_valid;
        @(posedge clk);
        #1;
        dev_tx_pop = 1'b0;
    endtask

    initial begin
        int          fd;
        int          t;
        string       line;
        logic [31:0] op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] got;

        rst_n       = 1'b0;
        awaddr      = '0;
        awvalid     = 1'b0;
        wdata       = '0;
        wvalid      = 1'b0;
        bready      = 1'b0;
        araddr      = '0;
        arvalid     = 1'b0;
        rready      = 1'b0;
        dev_tx_pop  = 1'b0;
        dev_rx_push = 1'b0;
        dev_rx_data = '0;
        dev_rx_tag  = '0;

        fd = $fopen("tests/mbox_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Skip comments and blank lines
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%s %h %h %d", op, a, d, t) == 4) begin
                        op_q.push_back(op);
                        addr_q.push_back(a);
                        data_q.push_back(d);
                        test_q.push_back(t);
                    end
                end
            end
            $fclose(fd);
        end
        if (op_q.size() == 0) begin
            $display("the trace holds no operations");
            errors++;
        end
        limit = 40 * (op_q.size() + 1);

        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        foreach (op_q[i]) begin
            if (test_q[i] != cur_test) begin
                if (cur_test != 0) begin
                    report_test();
                end
                cur_test    = test_q[i];
                test_checks = 0;
                test_errors = 0;
            end
            case (op_q[i])
                "WR":   axi_write(addr_q[i][AXI_AW-1:0], data_q[i]);
                "RD": begin
                    axi_read(addr_q[i][AXI_AW-1:0], got);
                    check_value("rdata", data_q[i], got);
                    if (addr_q[i][AXI_AW-1:0] == REG_RX_DATA && rx_level > 0) begin
                        rx_level--;
                    end
                end
                "PUSH": device_push(addr_q[i][TAG_W-1:0], data_q[i]);
                "POP":  device_pop(addr_q[i][0], data_q[i]);
                default: begin
                    $display("unknown operation on trace entry %0d", i);
                    errors++;
                end
            endcase
        end
        if (cur_test != 0) begin
            report_test();
        end

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: tests/mbox_trace.txt
# op  addr/tag  data  test
# WR axi write, RD axi read with expected data, PUSH device push (tag), POP device pop (addr = expected valid)
WR   00 11110001 1
WR   00 11110002 1
POP  1  11110001 1
POP  1  11110002 1
POP  0  11110002 1
PUSH 3  aaaa0001 2
PUSH 5  aaaa0002 2
RD   08 00000003 2
RD   08 00000003 2
RD   04 aaaa0001 2
RD   08 00000005 2
RD   04 aaaa0002 2
PUSH 7  bbbb0001 3
WR   00 22220001 3
WR   00 22220002 3
WR   00 22220003 3
WR   00 22220004 3
WR   00 22220005 3
WR   00 22220006 3
RD   0c 00002126 3
WR   00 22220007 3
WR   00 22220008 3
RD   0c 00002138 3
WR   00 deadbeef 4
RD   0c 00002178 4
RD   10 00000001 4
POP  1  22220001 4
POP  1  22220002 4
POP  1  22220003 4
POP  1  22220004 4
POP  1  22220005 4
POP  1  22220006 4
POP  1  22220007 4
POP  1  22220008 4
POP  0  22220008 4
RD   04 bbbb0001 5
RD   04 bbbb0001 5
RD   0c 00005040 5
RD   10 00010001 5
WR   14 00000001 6
RD   0c 00001000 6
RD   10 00010001 6
